// File: design/blit_pkg.sv
package blit_pkg;

    localparam int COORD_W  = 16;
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int COLOUR_W = 16;

    typedef logic [COORD_W-1:0]  coord_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [COLOUR_W-1:0] colour_t;

    // source pixel layout in memory
    typedef enum logic {
        FMT_RGB16  = 1'b0,
        FMT_INDEX8 = 1'b1
    } pixel_format_t;

    typedef enum logic {W_IDLE, W_RUN} walker_state_t;

    typedef enum logic [1:0] {F_IDLE, F_READ, F_HOLD} fetch_state_t;

    typedef enum logic {P_IDLE, P_READ} palette_state_t;

endpackage

// File: design/rect_walker.sv
`timescale 1ns/1ps

module rect_walker #(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    input  blit_pkg::coord_t cmd_src_x,
    input  blit_pkg::coord_t cmd_src_y,
    input  blit_pkg::coord_t cmd_dst_x,
    input  blit_pkg::coord_t cmd_dst_y,
    input  blit_pkg::coord_t cmd_width,
    input  blit_pkg::coord_t cmd_height,
    input  blit_pkg::coord_t cmd_scale_x,
    input  blit_pkg::coord_t cmd_scale_y,
    input  logic             cmd_mirror_x,
    input  logic             cmd_mirror_y,
    output logic             walk_valid,
    input  logic             walk_ready,
    output blit_pkg::coord_t walk_src_x,
    output blit_pkg::coord_t walk_src_y,
    output blit_pkg::coord_t walk_dst_x,
    output blit_pkg::coord_t walk_dst_y,
    output logic             walker_busy
);

    blit_pkg::walker_state_t state;
    blit_pkg::coord_t src_x0, src_cx, src_cy, dst_x0, dst_y0;
    blit_pkg::coord_t last_i, last_j, last_sx, last_sy; // inclusive limits
    blit_pkg::coord_t off_i, off_j, sub_x, sub_y;
    logic mirror_x, mirror_y;
    logic running, visible, advance, empty_cmd;

    assign running     = (state == blit_pkg::W_RUN);
    assign walker_busy = running;

    assign walk_src_x = src_cx;
    assign walk_src_y = src_cy;
    assign walk_dst_x = mirror_x ? dst_x0 + last_i - off_i : dst_x0 + off_i;
    assign walk_dst_y = mirror_y ? dst_y0 + last_j - off_j : dst_y0 + off_j;

    assign visible    = (walk_dst_x < FB_WIDTH) && (walk_dst_y < FB_HEIGHT);
    assign walk_valid = running && visible;
    assign advance    = running && (!visible || walk_ready); // clipped offsets just pass

    assign empty_cmd = (cmd_width == '0) || (cmd_height == '0) ||
                       (cmd_scale_x == '0) || (cmd_scale_y == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= blit_pkg::W_IDLE;
            cmd_ready <= 1'b0;
        end else if (!running) begin
            cmd_ready <= 1'b1;
            if (cmd_valid && cmd_ready) begin
                cmd_ready <= 1'b0;
                if (!empty_cmd)
                    state <= blit_pkg::W_RUN;
            end
        end else if (advance && off_i == last_i && off_j == last_j) begin
            state     <= blit_pkg::W_IDLE;
            cmd_ready <= 1'b1;
        end
    end

    // command latch and offset stepping
    always_ff @(posedge clk) begin
        if (!running && cmd_valid && cmd_ready) begin
            src_x0   <= cmd_src_x;
            src_cx   <= cmd_src_x;
            src_cy   <= cmd_src_y;
            dst_x0   <= cmd_dst_x;
            dst_y0   <= cmd_dst_y;
            last_i   <= cmd_width - 1'b1;
            last_j   <= cmd_height - 1'b1;
            last_sx  <= cmd_scale_x - 1'b1;
            last_sy  <= cmd_scale_y - 1'b1;
            mirror_x <= cmd_mirror_x;
            mirror_y <= cmd_mirror_y;
            off_i    <= '0;
            off_j    <= '0;
            sub_x    <= '0;
            sub_y    <= '0;
        end else if (advance) begin
            if (off_i == last_i) begin // next row
                off_i  <= '0;
                sub_x  <= '0;
                src_cx <= src_x0;
                off_j  <= off_j + 1'b1;
                if (sub_y == last_sy) begin
                    sub_y  <= '0;
                    src_cy <= src_cy + 1'b1;
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
            end else begin
                off_i <= off_i + 1'b1;
                if (sub_x == last_sx) begin
                    sub_x  <= '0;
                    src_cx <= src_cx + 1'b1;
                end else begin
                    sub_x <= sub_x + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/texel_fetch.sv
`timescale 1ns/1ps

module texel_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        walk_valid,
    output logic                        walk_ready,
    input  blit_pkg::coord_t            walk_src_x,
    input  blit_pkg::coord_t            walk_src_y,
    input  blit_pkg::coord_t            walk_dst_x,
    input  blit_pkg::coord_t            walk_dst_y,
    input  blit_pkg::addr_t             image_base,
    input  blit_pkg::coord_t            image_stride,
    input  blit_pkg::pixel_format_t     pixel_format,
    output logic                        tex_req,
    output blit_pkg::addr_t             tex_addr,
    input  logic                        tex_done,
    input  logic [blit_pkg::DATA_W-1:0] rdata,
    output logic                        pix_valid,
    input  logic                        pix_ready,
    output blit_pkg::colour_t           pix_data,
    output blit_pkg::coord_t            pix_x,
    output blit_pkg::coord_t            pix_y,
    output logic                        fetch_busy
);

    blit_pkg::fetch_state_t state;
    blit_pkg::addr_t        pix_offset;
    blit_pkg::colour_t      texel;
    logic [7:0]             texel_byte;

    assign walk_ready = (state == blit_pkg::F_IDLE);
    assign tex_req    = (state == blit_pkg::F_READ);
    assign pix_valid  = (state == blit_pkg::F_HOLD);
    assign fetch_busy = (state != blit_pkg::F_IDLE);

    // linear pixel index within the image
    assign pix_offset = blit_pkg::addr_t'(walk_src_x) +
                        blit_pkg::addr_t'(image_stride) * blit_pkg::addr_t'(walk_src_y);

    always_comb begin
        case (tex_addr[1:0])
            2'd0:    texel_byte = rdata[7:0];
            2'd1:    texel_byte = rdata[15:8];
            2'd2:    texel_byte = rdata[23:16];
            default: texel_byte = rdata[31:24];
        endcase
        if (pixel_format == blit_pkg::FMT_RGB16)
            texel = tex_addr[1] ? rdata[31:16] : rdata[15:0];
        else
            texel = {8'h00, texel_byte}; // palette index
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= blit_pkg::F_IDLE;
        end else begin
            case (state)
                blit_pkg::F_IDLE: if (walk_valid) state <= blit_pkg::F_READ;
                blit_pkg::F_READ: if (tex_done) state <= blit_pkg::F_HOLD;
                default:          if (pix_ready) state <= blit_pkg::F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (walk_valid && walk_ready) begin
            tex_addr <= (pixel_format == blit_pkg::FMT_RGB16) ?
                        image_base + (pix_offset << 1) : image_base + pix_offset;
            pix_x    <= walk_dst_x;
            pix_y    <= walk_dst_y;
        end
        if (tex_req && tex_done)
            pix_data <= texel;
    end

endmodule

// File: design/palette_lookup.sv
`timescale 1ns/1ps

module palette_lookup (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pix_valid,
    output logic                        pix_ready,
    input  blit_pkg::colour_t           pix_data,
    input  blit_pkg::coord_t            pix_x,
    input  blit_pkg::coord_t            pix_y,
    input  blit_pkg::pixel_format_t     pixel_format,
    input  blit_pkg::addr_t             palette_base,
    output logic                        pal_req,
    output blit_pkg::addr_t             pal_addr,
    input  logic                        pal_done,
    input  logic [blit_pkg::DATA_W-1:0] rdata,
    input  logic                        fetch_busy,
    input  logic                        walker_busy,
    output blit_pkg::coord_t            fb_x,
    output blit_pkg::coord_t            fb_y,
    output blit_pkg::colour_t           fb_colour,
    output logic                        fb_write,
    output logic                        busy
);

    blit_pkg::palette_state_t state;
    logic                     pix_fire;

    assign pix_ready = (state == blit_pkg::P_IDLE);
    assign pal_req   = (state == blit_pkg::P_READ);
    assign pix_fire  = pix_valid && pix_ready;

    // whole pipeline, up to and including the final write
    assign busy = walker_busy || fetch_busy || pal_req || fb_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= blit_pkg::P_IDLE;
            fb_write <= 1'b0;
        end else begin
            fb_write <= 1'b0;
            if (pix_fire) begin
                if (pixel_format == blit_pkg::FMT_RGB16)
                    fb_write <= 1'b1;
                else
                    state <= blit_pkg::P_READ;
            end else if (pal_req && pal_done) begin
                fb_write <= 1'b1;
                state    <= blit_pkg::P_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_fire) begin
            fb_x      <= pix_x;
            fb_y      <= pix_y;
            fb_colour <= pix_data; // final colour for rgb16
            pal_addr  <= palette_base + blit_pkg::addr_t'({pix_data, 1'b0});
        end else if (pal_req && pal_done) begin
            fb_colour <= pal_addr[1] ? rdata[31:16] : rdata[15:0];
        end
    end

endmodule

// File: design/apb_arbiter.sv
`timescale 1ns/1ps

module apb_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tex_req,
    input  blit_pkg::addr_t             tex_addr,
    output logic                        tex_done,
    input  logic                        pal_req,
    input  blit_pkg::addr_t             pal_addr,
    output logic                        pal_done,
    output logic [blit_pkg::DATA_W-1:0] rdata,
    output blit_pkg::addr_t             paddr,
    output logic                        psel,
    output logic                        penable,
    input  logic [blit_pkg::DATA_W-1:0] prdata,
    input  logic                        pready
);

    logic            owner_pal; // current transfer belongs to palette
    logic            start;
    blit_pkg::addr_t grant_addr;

    // requester still sees its done this cycle, so hold off
    assign start      = !psel && !tex_done && !pal_done && (pal_req || tex_req);
    assign grant_addr = pal_req ? pal_addr : tex_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            psel     <= 1'b0;
            penable  <= 1'b0;
            tex_done <= 1'b0;
            pal_done <= 1'b0;
        end else begin
            tex_done <= 1'b0;
            pal_done <= 1'b0;
            if (start) begin
                psel <= 1'b1; // setup phase
            end else if (psel && !penable) begin
                penable <= 1'b1;
            end else if (psel && pready) begin
                psel     <= 1'b0;
                penable  <= 1'b0;
                tex_done <= !owner_pal;
                pal_done <= owner_pal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            owner_pal <= pal_req;
            paddr     <= {grant_addr[blit_pkg::ADDR_W-1:2], 2'b00};
        end
        if (psel && penable && pready)
            rdata <= prdata;
    end

endmodule

// File: design/blit_top.sv
`timescale 1ns/1ps

module blit_top #(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  blit_pkg::coord_t              cmd_src_x,
    input  blit_pkg::coord_t              cmd_src_y,
    input  blit_pkg::coord_t              cmd_dst_x,
    input  blit_pkg::coord_t              cmd_dst_y,
    input  blit_pkg::coord_t              cmd_width,
    input  blit_pkg::coord_t              cmd_height,
    input  blit_pkg::coord_t              cmd_scale_x,
    input  blit_pkg::coord_t              cmd_scale_y,
    input  logic                          cmd_mirror_x,
    input  logic                          cmd_mirror_y,
    input  blit_pkg::addr_t               image_base,
    input  blit_pkg::coord_t              image_stride,
    input  blit_pkg::pixel_format_t       pixel_format,
    input  blit_pkg::addr_t               palette_base,
    output logic                          busy,
    output blit_pkg::addr_t               paddr,
    output logic                          psel,
    output logic                          penable,
    input  logic [blit_pkg::DATA_W-1:0]   prdata,
    input  logic                          pready,
    output blit_pkg::coord_t              fb_x,
    output blit_pkg::coord_t              fb_y,
    output blit_pkg::colour_t             fb_colour,
    output logic                          fb_write
);

    logic walk_valid, walk_ready, walker_busy;
    blit_pkg::coord_t walk_src_x, walk_src_y, walk_dst_x, walk_dst_y;

    logic pix_valid, pix_ready, fetch_busy;
    blit_pkg::colour_t pix_data;
    blit_pkg::coord_t pix_x, pix_y;

    logic tex_req, tex_done, pal_req, pal_done;
    blit_pkg::addr_t tex_addr, pal_addr;
    logic [blit_pkg::DATA_W-1:0] rdata; // shared by both stages

    rect_walker #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) walker_i (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd_src_x(cmd_src_x), .cmd_src_y(cmd_src_y),
        .cmd_dst_x(cmd_dst_x), .cmd_dst_y(cmd_dst_y),
        .cmd_width(cmd_width), .cmd_height(cmd_height),
        .cmd_scale_x(cmd_scale_x), .cmd_scale_y(cmd_scale_y),
        .cmd_mirror_x(cmd_mirror_x), .cmd_mirror_y(cmd_mirror_y),
        .walk_valid(walk_valid), .walk_ready(walk_ready),
        .walk_src_x(walk_src_x), .walk_src_y(walk_src_y),
        .walk_dst_x(walk_dst_x), .walk_dst_y(walk_dst_y),
        .walker_busy(walker_busy)
    );

    texel_fetch fetch_i (
        .clk(clk), .rst(rst),
        .walk_valid(walk_valid), .walk_ready(walk_ready),
        .walk_src_x(walk_src_x), .walk_src_y(walk_src_y),
        .walk_dst_x(walk_dst_x), .walk_dst_y(walk_dst_y),
        .image_base(image_base), .image_stride(image_stride),
        .pixel_format(pixel_format),
        .tex_req(tex_req), .tex_addr(tex_addr), .tex_done(tex_done), .rdata(rdata),
        .pix_valid(pix_valid), .pix_ready(pix_ready),
        .pix_data(pix_data), .pix_x(pix_x), .pix_y(pix_y),
        .fetch_busy(fetch_busy)
    );

    palette_lookup palette_i (
        .clk(clk), .rst(rst),
        .pix_valid(pix_valid), .pix_ready(pix_ready),
        .pix_data(pix_data), .pix_x(pix_x), .pix_y(pix_y),
        .pixel_format(pixel_format), .palette_base(palette_base),
        .pal_req(pal_req), .pal_addr(pal_addr), .pal_done(pal_done), .rdata(rdata),
        .fetch_busy(fetch_busy), .walker_busy(walker_busy),
        .fb_x(fb_x), .fb_y(fb_y), .fb_colour(fb_colour), .fb_write(fb_write),
        .busy(busy)
    );

    apb_arbiter arbiter_i (
        .clk(clk), .rst(rst),
        .tex_req(tex_req), .tex_addr(tex_addr), .tex_done(tex_done),
        .pal_req(pal_req), .pal_addr(pal_addr), .pal_done(pal_done),
        .rdata(rdata),
        .paddr(paddr), .psel(psel), .penable(penable),
        .prdata(prdata), .pready(pready)
    );

endmodule

// File: tests/blit_checker.sv
`timescale 1ns/1ps

module blit_checker #(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  blit_pkg::coord_t        cmd_src_x,
    input  blit_pkg::coord_t        cmd_src_y,
    input  blit_pkg::coord_t        cmd_dst_x,
    input  blit_pkg::coord_t        cmd_dst_y,
    input  blit_pkg::coord_t        cmd_width,
    input  blit_pkg::coord_t        cmd_height,
    input  blit_pkg::coord_t        cmd_scale_x,
    input  blit_pkg::coord_t        cmd_scale_y,
    input  logic                    cmd_mirror_x,
    input  logic                    cmd_mirror_y,
    input  blit_pkg::addr_t         image_base,
    input  blit_pkg::coord_t        image_stride,
    input  blit_pkg::pixel_format_t pixel_format,
    input  blit_pkg::addr_t         palette_base,
    input  logic                    busy,
    input  logic                    psel,
    input  blit_pkg::coord_t        fb_x,
    input  blit_pkg::coord_t        fb_y,
    input  blit_pkg::colour_t       fb_colour,
    input  logic                    fb_write,
    input  logic                    test_done,
    input  int                      test_index,
    input  int                      expected_writes,
    output int                      error_count,
    output int                      tests_passed,
    output int                      tests_failed
);

    logic [47:0] expected_q [$]; // {x, y, colour}
    int          writes_seen;
    int          errors_before;
    int          after_rst;
    bit          reset_seen;

    initial begin
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        writes_seen  = 0;
        errors_before = 0;
        after_rst    = 0;
    end

    // low half is the word index and high half its inverse
    function automatic logic [15:0] halfword_at(input logic [31:0] a);
        logic [15:0] w;
        w = a[17:2];
        return a[1] ? ~w : w;
    endfunction

    function automatic logic [7:0] byte_at(input logic [31:0] a);
        logic [31:0] word;
        word = {~a[17:2], a[17:2]};
        return word[8 * a[1:0] +: 8];
    endfunction

    task automatic predict_command();
        int          i, j;
        logic [15:0] x, y, sx, sy, colour;
        logic [31:0] a;
        expected_q.delete();
        if (cmd_width != 0 && cmd_height != 0 && cmd_scale_x != 0 && cmd_scale_y != 0) begin
            for (j = 0; j < int'(cmd_height); j++) begin
                for (i = 0; i < int'(cmd_width); i++) begin
                    x = cmd_mirror_x ? cmd_dst_x + cmd_width - 16'd1 - 16'(i)
                                     : cmd_dst_x + 16'(i);
                    y = cmd_mirror_y ? cmd_dst_y + cmd_height - 16'd1 - 16'(j)
                                     : cmd_dst_y + 16'(j);
                    if (int'(x) < FB_WIDTH && int'(y) < FB_HEIGHT) begin
                        sx = cmd_src_x + 16'(i / int'(cmd_scale_x));
                        sy = cmd_src_y + 16'(j / int'(cmd_scale_y));
                        if (pixel_format == blit_pkg::FMT_RGB16) begin
                            a = image_base + 32'd2 * (32'(sx) + 32'(image_stride) * 32'(sy));
                            colour = halfword_at(a);
                        end else begin
                            a = image_base + 32'(sx) + 32'(image_stride) * 32'(sy);
                            colour = halfword_at(palette_base + 32'd2 * 32'(byte_at(a)));
                        end
                        expected_q.push_back({x, y, colour});
                    end
                end
            end
        end
    endtask

    task automatic compare(input string name, input logic [15:0] exp_v, input logic [15:0] act);
        if (act !== exp_v) begin
            $display("mismatch at %0t: %s expected 0x%04h, actual 0x%04h", $time, name, exp_v, act);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        logic [47:0] front;
        if (reset_seen && (rst || after_rst <= 1) && (fb_write !== 1'b0 || psel !== 1'b0)) begin
            $display("error at %0t: fb_write or psel active around reset", $time);
            error_count++;
        end
        if (!rst && after_rst == 1 && cmd_ready !== 1'b1) begin
            $display("error at %0t: cmd_ready did not rise the cycle after reset", $time);
            error_count++;
        end
        if (rst) begin
            reset_seen = 1'b1;
            after_rst  = 0;
        end else if (after_rst < 2) begin
            after_rst++;
        end

        // busy must cover every pixel still owed by the current command
        if (expected_q.size() != 0 && busy !== 1'b1) begin
            $display("error at %0t: busy is low with %0d pixels still to draw",
                     $time, expected_q.size());
            error_count++;
        end

        if (cmd_valid && cmd_ready) begin
            predict_command();
            writes_seen   = 0;
            errors_before = error_count;
        end

        if (fb_write === 1'b1) begin
            writes_seen++;
            if (expected_q.size() == 0) begin
                $display("error at %0t: frame-buffer write with no pixel left to draw", $time);
                error_count++;
            end else begin
                front = expected_q.pop_front();
                compare("fb_x", front[47:32], fb_x);
                compare("fb_y", front[31:16], fb_y);
                compare("fb_colour", front[15:0], fb_colour);
            end
        end

        if (test_done) begin
            if (expected_q.size() != 0) begin
                $display("test %0d: %0d pixels never written", test_index + 1, expected_q.size());
                error_count++;
                expected_q.delete();
            end
            if (writes_seen != expected_writes) begin
                $display("test %0d: %0d writes seen but the vector file expects %0d",
                         test_index + 1, writes_seen, expected_writes);
                error_count++;
            end
            if (error_count == errors_before) begin
                tests_passed++;
                $display("test %0d: %0d writes, pass", test_index + 1, writes_seen);
            end else begin
                tests_failed++;
                $display("test %0d: %0d writes, FAIL", test_index + 1, writes_seen);
            end
        end
    end

endmodule

// File: tests/blit_tb.sv
`timescale 1ns/1ps

module blit_tb;

    localparam int FB_WIDTH  = 400;
    localparam int FB_HEIGHT = 240;
    localparam int FIELDS    = 15; // hex fields per vector line
    localparam int MAX_TESTS = 32;
    localparam int CLK_HALF  = 4;

    logic                        clk;
    logic                        rst;
    logic                        cmd_valid;
    logic                        cmd_ready;
    blit_pkg::coord_t            cmd_src_x, cmd_src_y, cmd_dst_x, cmd_dst_y;
    blit_pkg::coord_t            cmd_width, cmd_height, cmd_scale_x, cmd_scale_y;
    logic                        cmd_mirror_x, cmd_mirror_y;
    blit_pkg::addr_t             image_base, palette_base;
    blit_pkg::coord_t            image_stride;
    blit_pkg::pixel_format_t     pixel_format;
    logic                        busy;
    blit_pkg::addr_t             paddr;
    logic                        psel, penable, pready;
    logic [blit_pkg::DATA_W-1:0] prdata;
    blit_pkg::coord_t            fb_x, fb_y;
    blit_pkg::colour_t           fb_colour;
    logic                        fb_write;

    logic        test_done;
    int          test_index, expected_writes;
    int          error_count, tests_passed, tests_failed;
    logic [31:0] vectors [0:FIELDS*MAX_TESTS-1];
    int          num_tests;
    int          limit_cycles;
    logic [15:0] lfsr;
    logic [1:0]  wait_left;

    blit_top #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) dut_i (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd_src_x(cmd_src_x), .cmd_src_y(cmd_src_y),
        .cmd_dst_x(cmd_dst_x), .cmd_dst_y(cmd_dst_y),
        .cmd_width(cmd_width), .cmd_height(cmd_height),
        .cmd_scale_x(cmd_scale_x), .cmd_scale_y(cmd_scale_y),
        .cmd_mirror_x(cmd_mirror_x), .cmd_mirror_y(cmd_mirror_y),
        .image_base(image_base), .image_stride(image_stride),
        .pixel_format(pixel_format), .palette_base(palette_base),
        .busy(busy),
        .paddr(paddr), .psel(psel), .penable(penable),
        .prdata(prdata), .pready(pready),
        .fb_x(fb_x), .fb_y(fb_y), .fb_colour(fb_colour), .fb_write(fb_write)
    );

    blit_checker #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) checker_i (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd_src_x(cmd_src_x), .cmd_src_y(cmd_src_y),
        .cmd_dst_x(cmd_dst_x), .cmd_dst_y(cmd_dst_y),
        .cmd_width(cmd_width), .cmd_height(cmd_height),
        .cmd_scale_x(cmd_scale_x), .cmd_scale_y(cmd_scale_y),
        .cmd_mirror_x(cmd_mirror_x), .cmd_mirror_y(cmd_mirror_y),
        .image_base(image_base), .image_stride(image_stride),
        .pixel_format(pixel_format), .palette_base(palette_base),
        .busy(busy), .psel(psel),
        .fb_x(fb_x), .fb_y(fb_y), .fb_colour(fb_colour), .fb_write(fb_write),
        .test_done(test_done), .test_index(test_index),
        .expected_writes(expected_writes),
        .error_count(error_count), .tests_passed(tests_passed),
        .tests_failed(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] memory_word(input blit_pkg::addr_t a);
        logic [15:0] w;
        w = a[17:2];
        return {~w, w};
    endfunction

    // APB memory, 0 to 3 wait states per transfer
    always @(posedge clk) begin
        #1;
        if (rst || !psel) begin
            pready = 1'b0;
        end else if (!penable) begin
            lfsr = lfsr_step(lfsr);
            wait_left[0] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            wait_left[1] = lfsr[0];
            prdata = memory_word(paddr);
        end else if (!pready) begin
            if (wait_left == 2'd0)
                pready = 1'b1;
            else
                wait_left = wait_left - 2'd1;
        end
    end

    task automatic run_command(input int t);
        int base;
        base = t * FIELDS;
        while (!(cmd_ready && !busy)) begin
            @(posedge clk);
            #1;
        end
        cmd_src_x    = vectors[base][15:0];
        cmd_src_y    = vectors[base+1][15:0];
        cmd_dst_x    = vectors[base+2][15:0];
        cmd_dst_y    = vectors[base+3][15:0];
        cmd_width    = vectors[base+4][15:0];
        cmd_height   = vectors[base+5][15:0];
        cmd_scale_x  = vectors[base+6][15:0];
        cmd_scale_y  = vectors[base+7][15:0];
        cmd_mirror_x = vectors[base+8][0];
        cmd_mirror_y = vectors[base+9][0];
        image_base   = vectors[base+10];
        image_stride = vectors[base+11][15:0];
        pixel_format = blit_pkg::pixel_format_t'(vectors[base+12][0]);
        palette_base = vectors[base+13];
        cmd_valid    = 1'b1;
        @(posedge clk); // cmd_ready was high, so accepted here
        #1;
        cmd_valid = 1'b0;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        test_index      = t;
        expected_writes = int'(vectors[base+14]);
        test_done       = 1'b1;
        @(posedge clk);
        #1;
        test_done = 1'b0;
    endtask

    initial begin
        int k;
        int pixels;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_src_x    = '0;
        cmd_src_y    = '0;
        cmd_dst_x    = '0;
        cmd_dst_y    = '0;
        cmd_width    = '0;
        cmd_height   = '0;
        cmd_scale_x  = '0;
        cmd_scale_y  = '0;
        cmd_mirror_x = 1'b0;
        cmd_mirror_y = 1'b0;
        image_base   = '0;
        image_stride = '0;
        pixel_format = blit_pkg::FMT_RGB16;
        palette_base = '0;
        pready       = 1'b0;
        prdata       = '0;
        test_done    = 1'b0;
        test_index   = 0;
        expected_writes = 0;
        lfsr         = 16'd30;
        wait_left    = 2'd0;
        for (k = 0; k < FIELDS * MAX_TESTS; k++)
            vectors[k] = 32'hffff_ffff; // end marker
        $readmemh("tests/blit_vectors.txt", vectors);
        num_tests = 0;
        pixels    = 0;
        while (num_tests < MAX_TESTS && vectors[num_tests * FIELDS] != 32'hffff_ffff) begin
            pixels += int'(vectors[num_tests * FIELDS + 4] * vectors[num_tests * FIELDS + 5]);
            num_tests++;
        end
        limit_cycles = pixels * 40 + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (k = 0; k < num_tests; k++)
            run_command(k);
        @(posedge clk);
        #1;
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, tests_passed, tests_failed, error_count);
        if (num_tests > 0 && error_count == 0 && tests_passed == num_tests) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: tests/blit_vectors.txt
// blit commands, one per line, all fields hex
// src_x src_y dst_x dst_y width height scale_x scale_y mirror_x mirror_y
//   image_base stride format palette_base writes
// rgb16 scale 1, no mirror
3 2 a 14 4 3 1 1 0 0 1000 20 0 8000 c
// 2 by 3 blocks
1 1 32 28 6 6 2 3 0 0 1000 20 0 8000 24
// mirrored both ways
0 5 64 64 5 4 1 1 1 1 1000 20 0 8000 14
2 0 c8 10 4 2 2 1 1 0 3002 30 0 8000 8
// index8 through the palette
7 3 0 0 8 4 1 1 0 0 2000 40 1 4000 20
0 0 20 a0 6 4 3 2 0 1 2001 40 1 4102 18
5 1 120 50 10 8 1 1 1 1 2400 33 1 4000 80
// clipped at the right and bottom edges
0 0 18c ec 8 6 1 1 0 0 1000 20 0 8000 10
0 0 18e 0 5 3 1 1 1 0 2000 40 1 4000 6
9 9 e6 ee 3 5 1 2 0 1 1000 20 0 8000 6
// zero scale and zero width draw nothing
0 0 10 10 4 4 0 1 0 0 1000 20 0 8000 0
0 0 10 10 0 4 1 1 0 0 1000 20 0 8000 0
// single pixel straight after
4 4 0 0 1 1 1 1 0 0 1000 20 0 8000 1

// File: src.f
design/blit_pkg.sv
design/rect_walker.sv
design/texel_fetch.sv
design/palette_lookup.sv
design/apb_arbiter.sv
design/blit_top.sv
tests/blit_checker.sv
tests/blit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the blitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module blit_tb -f src.f -o blit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/blit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    exit 1
fi
exit 0
